/* verilog.f */
verilog/rfpg_pkg.sv
verilog/rf_port_if.sv
verilog/rf_bank_1024x12.sv
verilog/rf_pg_2048x12.sv
verilog/rf_init_sweeper.sv
verilog/rfpg_axil_ctrl.sv
verilog/rfpg_top.sv
bench/rfpg_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rfpg_tb -f verilog.f \
    -Mdir obj_dir -o rfpg_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/rfpg_sim)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

/* bench/rfpg_tb.sv */
// Randomized testbench for the AXI4-Lite state store with a 2048-entry reference model
// One access is in flight at a time, so every response is checked before the next request
module rfpg_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS          = 100;
    localparam int DRIVE_NS        = 5;
    localparam int WATCHDOG_CYCLES = 2 * rfpg_pkg::DEPTH + 600 * 12;
    localparam logic [8:0] NO_RSVD = 9'd0;

    logic                            rclk;
    logic                            rclk_rst_n;
    logic                            awvalid;
    logic                            awready;
    logic [rfpg_pkg::AXI_ADDR_W-1:0] awaddr;
    logic                            wvalid;
    logic                            wready;
    logic [rfpg_pkg::AXI_DATA_W-1:0] wdata;
    logic [3:0]                      wstrb;
    logic                            bvalid;
    logic                            bready;
    logic [1:0]                      bresp;
    logic                            arvalid;
    logic                            arready;
    logic [rfpg_pkg::AXI_ADDR_W-1:0] araddr;
    logic                            rvalid;
    logic                            rready;
    logic [rfpg_pkg::AXI_DATA_W-1:0] rdata;
    logic [1:0]                      rresp;
    logic                            pgcb_isol_en;
    logic                            pwr_enable_b_in;
    logic                            pwr_enable_b_out;
    logic                            ip_reset_b;

    // Reference model of the store, plus scratch state of the main sequence
    rfpg_pkg::rfpg_rdata_t           model [rfpg_pkg::DEPTH];
    integer                          seed;
    int                              ar_stall;
    int                              stall;
    int                              idx;
    logic [rfpg_pkg::AXI_DATA_W-1:0] rd;
    logic [1:0]                      rsp;
    logic                            d1;
    logic                            d2;
    logic                            pin;

    rfpg_top uut (.*);

    initial begin
        rclk = 1'b0;
        forever #(CLK_NS / 2) rclk = ~rclk;
    end

    // ********************
    // Reporting and checks
    // ********************

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_entry(input rfpg_pkg::rfpg_rdata_t got, input rfpg_pkg::rfpg_rdata_t exp,
                               input string what);
        if (got !== exp)
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp)
            report_failure($sformatf("MISMATCH at %0t: %s resp %b expected %b", $time, what, got, exp));
    endtask

    task automatic check_pwr(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_failure($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    // Whole 32-bit words, used for CSR reads and the unused upper data bits
    task automatic check_word(input logic [rfpg_pkg::AXI_DATA_W-1:0] got,
                              input logic [rfpg_pkg::AXI_DATA_W-1:0] exp, input string what);
        if (got !== exp)
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    // ********************
    // Stimulus helpers
    // ********************

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // A small pool in each bank so that reads often hit written entries
    function automatic int pick_entry();
        return rand_below(2) * rfpg_pkg::BANK_DEPTH + rand_below(32);
    endfunction

    function automatic logic [13:0] mem_addr(input int entry);
        return {1'b0, 11'(entry), 2'b00};
    endfunction

    function automatic logic [13:0] csr_addr(input logic [8:0] rsvd, input logic [1:0] sel);
        return {1'b1, rsvd, sel, 2'b00};
    endfunction

    // All AXI tasks start and end 5 ns after a rising edge, and sample on falling edges
    task automatic axi_write(input logic [13:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // Address and data ready have to move as one
        do begin
            @(negedge rclk);
            if (wready !== awready)
                report_failure("wready and awready did not rise and fall together");
        end while (!awready);
        @(posedge rclk);
        #DRIVE_NS;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge rclk);
        if (!bvalid) report_failure("bvalid did not rise one cycle after the write handshake");
        resp  = bresp;
        delay = rand_below(4);
        // The response has to sit still while bready stays low
        repeat (delay) begin
            @(negedge rclk);
            if (!bvalid || bresp !== resp)
                report_failure("write response dropped or changed while bready was low");
        end
        @(posedge rclk);
        #DRIVE_NS;
        bready = 1'b1;
        @(posedge rclk);
        #DRIVE_NS;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [13:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int delay;
        int lat;
        araddr   = addr;
        arvalid  = 1'b1;
        ar_stall = 0;
        @(negedge rclk);
        while (!arready) begin
            ar_stall++;
            @(negedge rclk);
        end
        @(posedge rclk);
        #DRIVE_NS;
        arvalid = 1'b0;
        lat     = 0;
        do begin
            @(negedge rclk);
            lat++;
        end while (!rvalid);
        // CSR answers after one cycle, the store needs one more for its registered read
        if (lat != (addr[13] ? 1 : 2))
            report_failure($sformatf("read response came %0d cycles after the handshake", lat));
        data  = rdata;
        resp  = rresp;
        delay = rand_below(4);
        repeat (delay) begin
            @(negedge rclk);
            if (!rvalid || rdata !== data || rresp !== resp)
                report_failure("read response dropped or changed while rready was low");
        end
        @(posedge rclk);
        #DRIVE_NS;
        rready = 1'b1;
        @(posedge rclk);
        #DRIVE_NS;
        rready = 1'b0;
    endtask

    // Writes under isolation never reach the bank, so the model keeps its old value
    task automatic write_entry(input int entry, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(mem_addr(entry), data, resp);
        check_resp(resp, rfpg_pkg::RESP_OKAY, "entry write");
        if (!pgcb_isol_en) model[entry] = data[rfpg_pkg::DATA_W-1:0];
    endtask

    task automatic read_entry(input int entry, input string what);
        logic [31:0]           data;
        logic [1:0]            resp;
        rfpg_pkg::rfpg_rdata_t exp;
        exp = pgcb_isol_en ? '0 : model[entry];
        axi_read(mem_addr(entry), data, resp);
        check_resp(resp, rfpg_pkg::RESP_OKAY, what);
        check_word({data[31:12], 12'h000}, 32'h0, "upper entry data bits");
        check_entry(data[rfpg_pkg::DATA_W-1:0], exp, what);
    endtask

    // The bus stays closed during a sweep, so the first status read waits it out
    task automatic wait_sweep_done(output int total_stall);
        logic [31:0] data;
        logic [1:0]  resp;
        total_stall = 0;
        do begin
            axi_read(csr_addr(NO_RSVD, rfpg_pkg::CSR_STATUS), data, resp);
            check_resp(resp, rfpg_pkg::RESP_OKAY, "status poll");
            total_stall += ar_stall;
        end while (data[0]);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        report_failure("timeout, the run did not finish within its cycle budget");
    end

    // ********************
    // Main sequence
    // ********************

    initial begin
        seed            = 22227;
        rclk_rst_n      = 1'b0;
        ip_reset_b      = 1'b0;
        awvalid         = 1'b0;
        awaddr          = '0;
        wvalid          = 1'b0;
        wdata           = '0;
        wstrb           = 4'hf;
        bready          = 1'b0;
        arvalid         = 1'b0;
        araddr          = '0;
        rready          = 1'b0;
        pgcb_isol_en    = 1'b0;
        pwr_enable_b_in = 1'b0;
        // The start-up sweep leaves every entry at zero
        for (int i = 0; i < rfpg_pkg::DEPTH; i++) model[i] = '0;
        repeat (4) @(posedge rclk);
        #DRIVE_NS;
        rclk_rst_n = 1'b1;
        ip_reset_b = 1'b1;
        repeat (2) @(posedge rclk);
        #DRIVE_NS;

        wait_sweep_done(stall);
        if (stall < rfpg_pkg::DEPTH - 8) report_failure("start-up sweep did not hold off the bus");
        repeat (50) read_entry(rand_below(rfpg_pkg::DEPTH), "post-reset read");

        // Mixed traffic over both banks
        repeat (400) begin
            idx = pick_entry();
            if (rand_below(2) == 1) write_entry(idx, $random(seed));
            else read_entry(idx, "mixed read");
        end

        // Isolated accesses, then the old contents again
        pgcb_isol_en = 1'b1;
        repeat (20) begin
            idx = pick_entry();
            write_entry(idx, $random(seed));
            read_entry(pick_entry(), "isolated read");
        end
        pgcb_isol_en = 1'b0;
        repeat (20) read_entry(pick_entry(), "read after isolation");

        // Output follows the input two edges later, d2 holds the value from two cycles back
        d1 = 1'b0;
        d2 = 1'b0;
        repeat (100) begin
            @(posedge rclk);
            #DRIVE_NS;
            check_pwr(pwr_enable_b_out, d2, "power chain output");
            pin             = rand_below(2) == 1;
            pwr_enable_b_in = pin;
            d2              = d1;
            d1              = pin;
        end
        for (int k = 0; k < 2; k++) begin
            pwr_enable_b_in = (k == 0);
            repeat (3) @(posedge rclk);
            #DRIVE_NS;
            axi_read(csr_addr(NO_RSVD, rfpg_pkg::CSR_STATUS), rd, rsp);
            check_resp(rsp, rfpg_pkg::RESP_OKAY, "status read");
            check_pwr(rd[1], k == 0, "status power bit");
        end

        // Commanded sweep, which keeps the bus closed for one cycle per entry
        axi_write(csr_addr(NO_RSVD, rfpg_pkg::CSR_CONTROL), 32'h1, rsp);
        check_resp(rsp, rfpg_pkg::RESP_OKAY, "control write");
        for (int i = 0; i < rfpg_pkg::DEPTH; i++) model[i] = '0;
        wait_sweep_done(stall);
        if (stall != rfpg_pkg::DEPTH)
            report_failure($sformatf("MISMATCH at %0t: sweep held the bus %0d cycles", $time, stall));
        repeat (30) read_entry(pick_entry(), "read after sweep");
        axi_read(csr_addr(NO_RSVD, rfpg_pkg::CSR_CONTROL), rd, rsp);
        check_resp(rsp, rfpg_pkg::RESP_OKAY, "control read");
        check_word(rd, 32'h0, "control read data")

;

        // Bad selects and a nonzero reserved field
        // A sweep started by any of these writes would stall the read right after it
        for (int s = 2; s < 4; s++) begin
            axi_write(csr_addr(NO_RSVD, 2'(s)), 32'h1, rsp);
            check_resp(rsp, rfpg_pkg::RESP_SLVERR, "write to unknown select");
            axi_read(csr_addr(NO_RSVD, 2'(s)), rd, rsp);
            check_resp(rsp, rfpg_pkg::RESP_SLVERR, "read of unknown select");
            if (ar_stall != 0) report_failure("a write to an unknown select started a sweep");
        end
        axi_write(csr_addr(9'(1 << rand_below(9)), rfpg_pkg::CSR_CONTROL), 32'h1, rsp);
        check_resp(rsp, rfpg_pkg::RESP_SLVERR, "write with reserved bits");
        axi_read(csr_addr(9'h100, rfpg_pkg::CSR_STATUS), rd, rsp);
        check_resp(rsp, rfpg_pkg::RESP_SLVERR, "read with reserved bits");
        if (ar_stall != 0) report_failure("a rejected control write started a sweep");
        axi_read(csr_addr(NO_RSVD, rfpg_pkg::CSR_STATUS), rd, rsp);
        check_resp(rsp, rfpg_pkg::RESP_OKAY, "status read after rejected writes");
        // The power input has been steady for many cycles, so the chain output matches it
        check_word(rd, {30'd0, pwr_enable_b_in, 1'b0}, "status after rejected writes");

        $display("sim passed");
        $finish;
    end

endmodule

/* verilog/rfpg_top.sv */
// Power-gated 2048x12 state store behind an AXI4-Lite slave
// Bus access is closed while the init sweep runs after reset or on command
module rfpg_top (
    input  logic                            rclk,
    input  logic                            rclk_rst_n,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [rfpg_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [rfpg_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [3:0]                      wstrb,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [rfpg_pkg::AXI_ADDR_W-1:0] araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [rfpg_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                      rresp,
    input  logic                            pgcb_isol_en,
    input  logic                            pwr_enable_b_in,
    output logic                            pwr_enable_b_out,
    input  logic                            ip_reset_b
);

    // Sweeper handshake with the control module
    logic                        sweep_start;
    logic                        sweep_busy;
    logic                        sw_we;
    logic [rfpg_pkg::ADDR_W-1:0] sw_addr;

    rf_port_if rf_port ();

    // The power chain output is also reported through CSR_STATUS
    rfpg_axil_ctrl u_ctrl (
        .rclk        (rclk),        .rclk_rst_n  (rclk_rst_n),
        .awvalid     (awvalid),     .awready     (awready),     .awaddr (awaddr),
        .wvalid      (wvalid),      .wready      (wready),      .wdata  (wdata),
        .wstrb       (wstrb),       .bvalid      (bvalid),      .bready (bready),
        .bresp       (bresp),       .arvalid     (arvalid),     .arready (arready),
        .araddr      (araddr),      .rvalid      (rvalid),      .rready (rready),
        .rdata       (rdata),       .rresp       (rresp),
        .pwr_status  (pwr_enable_b_out),
        .sweep_start (sweep_start), .sweep_busy  (sweep_busy),
        .sw_we       (sw_we),       .sw_addr     (sw_addr),
        .port        (rf_port.ctrl)
    );

    rf_init_sweeper u_sweeper (
        .rclk       (rclk),
        .rclk_rst_n (rclk_rst_n),
        .start      (sweep_start),
        .busy       (sweep_busy),
        .sw_we      (sw_we),
        .sw_addr    (sw_addr)
    );

    rf_pg_2048x12 u_store (
        .rclk             (rclk),
        .rclk_rst_n       (rclk_rst_n),
        .ip_reset_b       (ip_reset_b),
        .pgcb_isol_en     (pgcb_isol_en),
        .pwr_enable_b_in  (pwr_enable_b_in),
        .pwr_enable_b_out (pwr_enable_b_out),
        .port             (rf_port.store)
    );

endmodule

/* verilog/rfpg_axil_ctrl.sv */
// AXI4-Lite slave for the state store, one access in flight at a time
// WSTRB and AxPROT are ignored, every write stores the full entry
module rfpg_axil_ctrl (
    input  logic                            rclk,
    input  logic                            rclk_rst_n,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [rfpg_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [rfpg_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [3:0]                      wstrb,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [rfpg_pkg::AXI_ADDR_W-1:0] araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [rfpg_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                      rresp,
    input  logic                            pwr_status,
    output logic                            sweep_start,
    input  logic                            sweep_busy,
    input  logic                            sw_we,
    input  logic [rfpg_pkg::ADDR_W-1:0]     sw_addr,
    rf_port_if.ctrl                         port
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_RD_WAIT, ST_RD_RESP, ST_WR_RESP, ST_CSR_RESP
    } state_t;

    state_t                          state;
    rfpg_pkg::axil_addr_u            aw_u;
    rfpg_pkg::axil_addr_u            ar_u;
    logic                            wr_hs;
    logic                            rd_hs;
    logic                            aw_bad;
    logic                            ar_bad;
    logic [1:0]                      resp_q;
    logic                            start_pend;
    logic [rfpg_pkg::ADDR_W-1:0]     rd_idx_q;
    logic [rfpg_pkg::AXI_DATA_W-1:0] csr_rdata_q;

    // ********************
    // Decode and handshakes
    // ********************

    assign aw_u = awaddr;
    assign ar_u = araddr;

    // Control space errors are a nonzero reserved field or a select past CONTROL
    assign aw_bad = aw_u.csr.region && ((aw_u.csr.rsvd != '0) || aw_u.csr.sel[1]);
    assign ar_bad = ar_u.csr.region && ((ar_u.csr.rsvd != '0) || ar_u.csr.sel[1]);

    // Address and data are taken together, and only when both are offered
    assign awready = (state == ST_IDLE) && !sweep_busy && awvalid && wvalid;
    assign wready  = awready;
    assign wr_hs   = awready;

    // A complete write offer wins over a read in the same cycle
    assign arready = (state == ST_IDLE) && !sweep_busy && !(awvalid && wvalid);
    assign rd_hs   = arready && arvalid;

    // ********************
    // Response FSM
    // ********************

    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            state      <= ST_IDLE;
            resp_q     <= rfpg_pkg::RESP_OKAY;
            start_pend <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_hs) begin
                        state      <= ST_WR_RESP;
                        resp_q     <= aw_bad ? rfpg_pkg::RESP_SLVERR : rfpg_pkg::RESP_OKAY;
                        // Only a good CONTROL write with bit 0 set arms a sweep
                        start_pend <= aw_u.csr.region && !aw_bad && wdata[0]
                                      && (aw_u.csr.sel == rfpg_pkg::CSR_CONTROL);
                    end else if (rd_hs) begin
                        state  <= ar_u.mem.region ? ST_CSR_RESP : ST_RD_WAIT;
                        resp_q <= ar_bad ? rfpg_pkg::RESP_SLVERR : rfpg_pkg::RESP_OKAY;
                    end
                end
                ST_RD_WAIT:  state <= ST_RD_RESP;
                ST_RD_RESP:  if (rready) state <= ST_IDLE;
                ST_WR_RESP:  if (bready) state <= ST_IDLE;
                ST_CSR_RESP: if (rready) state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // Read index and CSR read value are captured at the AR handshake
    always_ff @(posedge rclk) begin
        if (rd_hs) begin
            rd_idx_q    <= ar_u.mem.index;
            csr_rdata_q <= '0;
            if (!ar_bad && (ar_u.csr.sel == rfpg_pkg::CSR_STATUS)) begin
                csr_rdata_q[1:0] <= {pwr_status, sweep_busy};
            end
        end
    end

    // The sweep follows the B handshake of the CONTROL write
    assign sweep_start = (state == ST_WR_RESP) && bready && start_pend;

    // ********************
    // Store port and responses
    // ********************

    // The sweep owns the write port while it runs, host writes land at the handshake edge
    assign port.we    = sweep_busy ? sw_we : (wr_hs && !aw_u.mem.region);
    assign port.waddr = sweep_busy ? sw_addr : aw_u.mem.index;
    assign port.wdata = sweep_busy ? '0 : wdata[rfpg_pkg::DATA_W-1:0];

    // The store read goes out one cycle after the AR handshake
    assign port.re    = (state == ST_RD_WAIT);
    assign port.raddr = rd_idx_q;

    assign bvalid = (state == ST_WR_RESP);
    assign bresp  = resp_q;
    assign rvalid = (state == ST_RD_RESP) || (state == ST_CSR_RESP);
    assign rresp  = resp_q;

    // Store data holds until the next re, which cannot come before rready
    assign rdata = (state == ST_RD_RESP) ? rfpg_pkg::AXI_DATA_W'(port.rdata) : csr_rdata_q;

endmodule

/* verilog/rf_init_sweeper.sv */
// Zeroes every entry of the store, one entry per cycle
// A sweep also starts on its own in the first cycle after reset
module rf_init_sweeper (
    input  logic                        rclk,
    input  logic                        rclk_rst_n,
    input  logic                        start,
    output logic                        busy,
    output logic                        sw_we,
    output logic [rfpg_pkg::ADDR_W-1:0] sw_addr
);

    localparam logic [rfpg_pkg::ADDR_W-1:0] LAST = rfpg_pkg::ADDR_W'(rfpg_pkg::DEPTH - 1);

    // Set by reset so that the first clock after release kicks off a sweep
    logic                        armed;
    logic [rfpg_pkg::ADDR_W-1:0] cnt;

    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            armed <= 1'b1;
            busy  <= 1'b0;
            cnt   <= '0;
        end else if (busy) begin
            // Step through the entries and stop after the last one
            cnt <= cnt + 1'b1;
            if (cnt == LAST) begin
                busy <= 1'b0;
            end
        end else if (armed || start) begin
            armed <= 1'b0;
            busy  <= 1'b1;
            cnt   <= '0;
        end
    end

    // Every busy cycle writes one entry
    assign sw_we   = busy;
    assign sw_addr = cnt;

endmodule

/* verilog/rf_pg_2048x12.sv */
// Two-bank state store, the top index bit picks the bank
// Single clock, the write side runs on rclk as well
module rf_pg_2048x12 (
    input  logic     rclk,
    input  logic     rclk_rst_n,
    input  logic     ip_reset_b,
    input  logic     pgcb_isol_en,
    input  logic     pwr_enable_b_in,
    output logic     pwr_enable_b_out,
    rf_port_if.store port
);

    localparam int TOP = rfpg_pkg::ADDR_W - 1;

    // Two flops of synchronizer for the ip reset
    logic [1:0]            ip_sync;
    logic                  ip_rst_n;

    // Registered bank select of the last read
    logic                  rd_sel;

    // Per-bank outputs and the power chain taps
    rfpg_pkg::rfpg_rdata_t bank_rdata [2];
    logic [2:0]            pwr_chain;

    // ********************
    // Ip reset synchronizer
    // ********************

    // Assertion is immediate and release is aligned to rclk
    always_ff @(posedge rclk or negedge ip_reset_b) begin
        if (!ip_reset_b) begin
            ip_sync <= 2'b00;
        end else begin
            ip_sync <= {ip_sync[0], 1'b1};
        end
    end

    assign ip_rst_n = ip_sync[1];

    // The select only moves on a read, so rdata holds between reads
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            rd_sel <= 1'b0;
        end else if (port.re) begin
            rd_sel <= port.raddr[TOP];
        end
    end

    // ********************
    // Bank array
    // ********************

    // Bank 0 gets the enable first and passes it on to bank 1
    assign pwr_chain[0] = pwr_enable_b_in;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        rf_bank_1024x12 u_bank (
            .rclk       (rclk),
            .rclk_rst_n (rclk_rst_n),
            .ip_rst_n   (ip_rst_n),
            .we         (port.we && (port.waddr[TOP] == 1'(b))),
            .waddr      (port.waddr[rfpg_pkg::BANK_ADDR_W-1:0]),
            .wdata      (port.wdata),
            .re         (port.re && (port.raddr[TOP] == 1'(b))),
            .raddr      (port.raddr[rfpg_pkg::BANK_ADDR_W-1:0]),
            .rdata      (bank_rdata[b]),
            .isol_en    (pgcb_isol_en),
            .pwr_in     (pwr_chain[b]),
            .pwr_out    (pwr_chain[b+1])
        );
    end

    assign pwr_enable_b_out = pwr_chain[2];

    // Steer the bank that served the last read onto the port
    assign port.rdata = rd_sel ? bank_rdata[1] : bank_rdata[0];

endmodule

/* verilog/rf_bank_1024x12.sv */
// One 1024x12 bank with registered read and output isolation
// Contents survive isolation, the bank is assumed to have retention
module rf_bank_1024x12 (
    input  logic                             rclk,
    input  logic                             rclk_rst_n,
    input  logic                             ip_rst_n,
    input  logic                             we,
    input  logic [rfpg_pkg::BANK_ADDR_W-1:0] waddr,
    input  rfpg_pkg::rfpg_rdata_t            wdata,
    input  logic                             re,
    input  logic [rfpg_pkg::BANK_ADDR_W-1:0] raddr,
    output rfpg_pkg::rfpg_rdata_t            rdata,
    input  logic                             isol_en,
    input  logic                             pwr_in,
    output logic                             pwr_out
);

    // The storage array itself
    rfpg_pkg::rfpg_rdata_t mem [rfpg_pkg::BANK_DEPTH];

    // ********************
    // Write path
    // ********************

    // A write that arrives under isolation never reaches the array
    always_ff @(posedge rclk) begin
        if (we && !isol_en) begin
            mem[waddr] <= wdata;
        end
    end

    // ********************
    // Read path
    // ********************

    // The output register is cleared by the synchronized ip reset
    // Under isolation the value captured on a read is forced to zero
    always_ff @(posedge rclk or negedge ip_rst_n) begin
        if (!ip_rst_n) begin
            rdata <= '0;
        end else if (re) begin
            if (isol_en) begin
                rdata <= '0;
            end else begin
                rdata <= mem[raddr];
            end
        end
    end

    // ********************
    // Power chain stage
    // ********************

    // One flop per bank, so the enable ripples down the chain a cycle at a time
    always_ff @(posedge rclk or negedge rclk_rst_n) begin
        if (!rclk_rst_n) begin
            pwr_out <= 1'b0;
        end else begin
            pwr_out <= pwr_in;
        end
    end

endmodule

/* verilog/rf_port_if.sv */
// Write and read port of the state store, driven by the control module
// Read data shows up one cycle after re and holds until the next re
interface rf_port_if;

    // Write side, the entry is updated on the clock edge where we is high
    logic                               we;
    logic [rfpg_pkg::ADDR_W-1:0]        waddr;
    rfpg_pkg::rfpg_rdata_t              wdata;

    // Read side
    logic                               re;
    logic [rfpg_pkg::ADDR_W-1:0]        raddr;
    rfpg_pkg::rfpg_rdata_t              rdata;

    // The control module issues all accesses
    modport ctrl (
        output we, waddr, wdata, re, raddr,
        input  rdata
    );

    // The store answers them
    modport store (
        input  we, waddr, wdata, re, raddr,
        output rdata
    );

endinterface

/* verilog/rfpg_pkg.sv */
// Shared widths, address map and response codes for the power-gated state store
// The byte address is 14 bits wide, and bit 13 splits the memory window from control space
package rfpg_pkg;

    // ********************
    // Store geometry
    // ********************

    localparam int DEPTH       = 2048;
    localparam int BANK_DEPTH  = 1024;
    localparam int ADDR_W      = 11;
    localparam int BANK_ADDR_W = 10;
    localparam int DATA_W      = 12;

    // ********************
    // AXI4-Lite bus
    // ********************

    localparam int AXI_ADDR_W = 14;
    localparam int AXI_DATA_W = 32;

    // Register selects within the control space
    localparam logic [1:0] CSR_STATUS  = 2'd0;
    localparam logic [1:0] CSR_CONTROL = 2'd1;

    // Response codes as carried on BRESP and RRESP
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // One stored entry
    typedef logic [DATA_W-1:0] rfpg_rdata_t;

    // Memory window view, where the word index picks one entry
    typedef struct packed {
        logic              region;
        logic [ADDR_W-1:0] index;
        logic [1:0]        offset;
    } axil_mem_addr_t;

    // Control space view, where the reserved field has to be zero
    typedef struct packed {
        logic       region;
        logic [8:0] rsvd;
        logic [1:0] sel;
        logic [1:0] offset;
    } axil_csr_addr_t;

    // The same address word read either way
    typedef union packed {
        axil_mem_addr_t mem;
        axil_csr_addr_t csr;
    } axil_addr_u;

endpackage
